/* include/skdecode_config.svh */
// Constants shared by the sk decode RTL and its testbench.
// Only eta = 2 is supported, so each packed code is 3 bits wide.
// Changing lanes or words also changes the register field layout.
`ifndef SKDECODE_CONFIG_SVH
`define SKDECODE_CONFIG_SVH

// ML-DSA modulus and the eta bound used for the s1 and s2 polynomials
`define SKD_MLDSA_Q 8380417
`define SKD_ETA 2
`define SKD_ETA_W 3

// coefficient width, enough for values below q
`define SKD_COEFF_W 24

// eight codes per key word, 32 words per 256-coefficient polynomial
`define SKD_LANES 8
`define SKD_WORDS 32
`define SKD_IDX_W 8

// AXI4-Lite slave sizing
`define SKD_AXI_ADDR_W 5
`define SKD_AXI_DATA_W 32

`endif

/* logic/skdecode_pkg.sv */
// Types shared by the sk decode blocks.
// Register addresses are byte addresses on word boundaries, and any other
// address is treated as unmapped.

`include "skdecode_config.svh"

package skdecode_pkg;

    // one unpacked coefficient, reduced modulo q
    typedef logic [`SKD_COEFF_W-1:0] coeff_t;

    // engine states
    // DONE and FAULT hold until firmware writes the CTRL clear bit
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE,
        FAULT
    } skd_state_e;

    // register map of the AXI4-Lite slave
    typedef enum logic [`SKD_AXI_ADDR_W-1:0] {
        // bit 0 clears the engine, reads as zero
        CTRL       = 'h00,
        // bit 0 done, bit 1 error, bits 13..8 word count
        STATUS     = 'h04,
        // packed key word, eight 3-bit codes in bits 23..0
        SK_DATA    = 'h08,
        // coefficient index for the next COEFF_DATA read
        COEFF_IDX  = 'h0C,
        // stored coefficient at COEFF_IDX, read only
        COEFF_DATA = 'h10
    } skd_reg_e;

endpackage

/* logic/skdecode_unpack_if.sv */
// Link between the register block and the unpack engine.
// sk_valid and clear are one-cycle pulses, and sk_valid is only raised
// while neither done nor error is set.

`include "skdecode_config.svh"

interface skdecode_unpack_if;

    // one accepted SK_DATA word, eight packed codes
    logic                                 sk_valid;
    logic [`SKD_LANES*`SKD_ETA_W-1:0]     sk_word;

    // return the engine to idle with count and flags zero
    logic                                 clear;

    // engine status, read back through STATUS
    logic                                 done;
    logic                                 error;
    logic [$clog2(`SKD_WORDS + 1)-1:0]    word_count;

    // the register block issues words and clears
    modport manager (
        output sk_valid, sk_word, clear,
        input  done, error, word_count
    );

    // the engine consumes words and reports its state
    modport worker (
        input  sk_valid, sk_word, clear,
        output done, error, word_count
    );

endinterface

/* logic/skdecode_s1s2_unpack.sv */
// One unpack lane for eta = 2 codes.
// Legal codes 0 to 4 map to eta minus code modulo q, codes 5 to 7 are flagged.
// Purely combinational, all outputs are zero while enable_i is low.

`include "skdecode_config.svh"

module skdecode_s1s2_unpack (
    input  logic [`SKD_ETA_W-1:0] data_i,
    input  logic                  enable_i,
    output skdecode_pkg::coeff_t  data_o,
    output logic                  valid_o,
    output logic                  error_o
);

    always_comb begin
        data_o  = '0;
        valid_o = 1'b0;
        error_o = 1'b0;

        if (enable_i) begin
            // the lane always answers when enabled, the error flag says if the code was legal
            valid_o = 1'b1;

            case (data_i)
                // codes up to eta give a non-negative result, 2, 1 or 0
                3'd0, 3'd1, 3'd2: begin
                    data_o = skdecode_pkg::coeff_t'(`SKD_ETA - data_i);
                end
                // codes above eta wrap to q-1 and q-2
                3'd3, 3'd4: begin
                    data_o = skdecode_pkg::coeff_t'(`SKD_MLDSA_Q + `SKD_ETA - data_i);
                end
                // 5 to 7 lie outside the eta range
                default: begin
                    data_o  = '0;
                    error_o = 1'b1;
                end
            endcase
        end
    end

endmodule

/* logic/skdecode_unpack_engine.sv */
// Unpacks one s1 or s2 polynomial, eight coefficients per key word.
// A word holding any invalid code is dropped and the engine stays in FAULT
// until a clear. Words arriving in DONE or FAULT are ignored.

`include "skdecode_config.svh"

module skdecode_unpack_engine (
    input  logic                                    clk,
    input  logic                                    reset_i,
    skdecode_unpack_if.worker                       unp,
    output logic                                    wr_en_o,
    output logic [$clog2(`SKD_WORDS)-1:0]           wr_addr_o,
    output skdecode_pkg::coeff_t [`SKD_LANES-1:0]   wr_data_o
);

    skdecode_pkg::skd_state_e               state_q;
    logic [$clog2(`SKD_WORDS + 1)-1:0]      count_q;
    skdecode_pkg::coeff_t [`SKD_LANES-1:0]  lane_data;
    logic [`SKD_LANES-1:0]                  lane_valid;
    logic [`SKD_LANES-1:0]                  lane_err;
    logic                                   word_in;
    logic                                   word_err;
    logic                                   word_ok;

    // code k of the word sits in bits 3k+2..3k
    for (genvar i = 0; i < `SKD_LANES; i++) begin : g_lane
        skdecode_s1s2_unpack u_lane (
            .data_i   (unp.sk_word[i*`SKD_ETA_W +: `SKD_ETA_W]),
            .enable_i (unp.sk_valid),
            .data_o   (lane_data[i]),
            .valid_o  (lane_valid[i]),
            .error_o  (lane_err[i])
        );
    end

    assign word_in  = &lane_valid;
    assign word_err = |lane_err;
    // only words that arrive while the polynomial is still filling are taken
    assign word_ok  = word_in && (state_q == skdecode_pkg::IDLE || state_q == skdecode_pkg::BUSY);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= skdecode_pkg::IDLE;
            count_q <= '0;
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= 1'b0;
            if (unp.clear) begin
                // stored coefficients stay, only the control state restarts
                state_q <= skdecode_pkg::IDLE;
                count_q <= '0;
            end else if (word_ok) begin
                if (word_err) begin
                    state_q <= skdecode_pkg::FAULT;
                end else begin
                    wr_en_o <= 1'b1;
                    count_q <= count_q + 1'b1;
                    // the last word of the polynomial completes it
                    if (count_q == `SKD_WORDS - 1) begin
                        state_q <= skdecode_pkg::DONE;
                    end else begin
                        state_q <= skdecode_pkg::BUSY;
                    end
                end
            end
        end
    end

    // write port payload, qualified by wr_en_o one cycle after the word
    always_ff @(posedge clk) begin
        if (word_ok) begin
            wr_addr_o <= count_q[$clog2(`SKD_WORDS)-1:0];
            wr_data_o <= lane_data;
        end
    end

    assign unp.done       = (state_q == skdecode_pkg::DONE);
    assign unp.error      = (state_q == skdecode_pkg::FAULT);
    assign unp.word_count = count_q;

endmodule

/* logic/skdecode_coeff_mem.sv */
// Coefficient store for one polynomial, written a whole word of eight
// coefficients at a time and read one coefficient at a time.
// Read data is registered, so it appears the cycle after rd_en_i.
// Contents are undefined until written and are not cleared by reset.

`include "skdecode_config.svh"

module skdecode_coeff_mem (
    input  logic                                   clk,
    input  logic                                   wr_en_i,
    input  logic [$clog2(`SKD_WORDS)-1:0]          wr_addr_i,
    input  skdecode_pkg::coeff_t [`SKD_LANES-1:0]  wr_data_i,
    input  logic                                   rd_en_i,
    input  logic [`SKD_IDX_W-1:0]                  rd_idx_i,
    output skdecode_pkg::coeff_t                   rd_data_o
);

    localparam int LaneW = $clog2(`SKD_LANES);

    // one entry per key word, lanes packed inside the entry
    skdecode_pkg::coeff_t [`SKD_LANES-1:0] mem_q [`SKD_WORDS];

    logic [$clog2(`SKD_WORDS)-1:0] rd_word;
    logic [LaneW-1:0]              rd_lane;

    // upper index bits pick the word, lower bits the lane within it
    assign rd_word = rd_idx_i[`SKD_IDX_W-1:LaneW];
    assign rd_lane = rd_idx_i[LaneW-1:0];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // the output holds its last value between reads
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_word][rd_lane];
        end
    end

endmodule

/* logic/skdecode_axil_regs.sv */
// AXI4-Lite slave for the sk decode registers.
// One read and one write may be open at a time, AW and W are taken together.
// WSTRB is ignored, every write is a full word.
// COEFF_DATA reads take one extra cycle for the coefficient memory.

`include "skdecode_config.svh"

module skdecode_axil_regs (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  logic [`SKD_AXI_ADDR_W-1:0]    awaddr_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    input  logic [`SKD_AXI_DATA_W-1:0]    wdata_i,
    input  logic [`SKD_AXI_DATA_W/8-1:0]  wstrb_i,
    output logic                          bvalid_o,
    input  logic                          bready_i,
    output logic [1:0]                    bresp_o,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    input  logic [`SKD_AXI_ADDR_W-1:0]    araddr_i,
    output logic                          rvalid_o,
    input  logic                          rready_i,
    output logic [`SKD_AXI_DATA_W-1:0]    rdata_o,
    output logic [1:0]                    rresp_o,
    skdecode_unpack_if.manager            unp,
    output logic                          rd_en_o,
    output logic [`SKD_IDX_W-1:0]         rd_idx_o,
    input  skdecode_pkg::coeff_t          rd_data_i
);

    localparam logic [1:0] RespOkay   = 2'b00;
    localparam logic [1:0] RespSlverr = 2'b10;

    logic                        wr_hs;
    logic                        ar_hs;
    logic [1:0]                  wr_resp;
    logic                        sk_accept;
    logic                        clr_req;
    logic                        idx_we;
    logic [`SKD_AXI_DATA_W-1:0]  rd_word;
    logic [1:0]                  rd_resp;
    logic                        rd_coeff;
    logic                        rd_pend_q;
    logic [`SKD_IDX_W-1:0]       coeff_idx_q;

    // awready and wready rise together and stay up one cycle
    assign wr_hs = awready_o & awvalid_i & wvalid_i;
    assign ar_hs = arready_o & arvalid_i;
    assign wready_o = awready_o;

    // write decode, STATUS, COEFF_DATA and unmapped addresses all fall to SLVERR
    always_comb begin
        wr_resp   = RespOkay;
        sk_accept = 1'b0;
        clr_req   = 1'b0;
        idx_we    = 1'b0;
        case (skdecode_pkg::skd_reg_e'(awaddr_i))
            skdecode_pkg::CTRL:      clr_req = wdata_i[0];
            skdecode_pkg::COEFF_IDX: idx_we = 1'b1;
            skdecode_pkg::SK_DATA: begin
                // a finished or faulted polynomial takes no more words
                if (unp.done || unp.error) begin
                    wr_resp = RespSlverr;
                end else begin
                    sk_accept = 1'b1;
                end
            end
            default:                 wr_resp = RespSlverr;
        endcase
    end

    // the engine sees the word in the handshake cycle and stores it on the next one
    assign unp.sk_valid = wr_hs & sk_accept;
    assign unp.sk_word  = wdata_i[`SKD_LANES*`SKD_ETA_W-1:0];
    assign unp.clear    = wr_hs & clr_req;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            awready_o   <= 1'b0;
            bvalid_o    <= 1'b0;
            bresp_o     <= RespOkay;
            coeff_idx_q <= '0;
        end else begin
            if (wr_hs) begin
                awready_o <= 1'b0;
                bvalid_o  <= 1'b1;
                bresp_o   <= wr_resp;
                if (idx_we) begin
                    coeff_idx_q <= wdata_i[`SKD_IDX_W-1:0];
                end
            end else if (bvalid_o) begin
                // no new address or data is taken until the response is gone
                if (bready_i) begin
                    bvalid_o <= 1'b0;
                end
            end else if (!awready_o && awvalid_i && wvalid_i) begin
                awready_o <= 1'b1;
            end
        end
    end

    // read decode, write-only registers read back as zero
    always_comb begin
        rd_word  = '0;
        rd_resp  = RespOkay;
        rd_coeff = 1'b0;
        case (skdecode_pkg::skd_reg_e'(araddr_i))
            skdecode_pkg::CTRL, skdecode_pkg::SK_DATA: rd_word = '0;
            skdecode_pkg::STATUS: begin
                rd_word[0]    = unp.done;
                rd_word[1]    = unp.error;
                rd_word[13:8] = unp.word_count;
            end
            skdecode_pkg::COEFF_IDX:  rd_word[`SKD_IDX_W-1:0] = coeff_idx_q;
            skdecode_pkg::COEFF_DATA: rd_coeff = 1'b1;
            default:                  rd_resp = RespSlverr;
        endcase
    end

    // memory lookup starts in the AR handshake cycle
    assign rd_en_o  = ar_hs & rd_coeff;
    assign rd_idx_o = coeff_idx_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rd_pend_q <= 1'b0;
            rdata_o   <= '0;
            rresp_o   <= RespOkay;
        end else begin
            if (ar_hs) begin
                arready_o <= 1'b0;
                if (rd_coeff) begin
                    rd_pend_q <= 1'b1;
                end else begin
                    rvalid_o <= 1'b1;
                    rdata_o  <= rd_word;
                    rresp_o  <= rd_resp;
                end
            end else if (rd_pend_q) begin
                // memory output is valid now, return it zero-extended
                rd_pend_q <= 1'b0;
                rvalid_o  <= 1'b1;
                rdata_o   <= {{(`SKD_AXI_DATA_W - `SKD_COEFF_W){1'b0}}, rd_data_i};
                rresp_o   <= RespOkay;
            end else if (rvalid_o) begin
                if (rready_i) begin
                    rvalid_o <= 1'b0;
                end
            end else if (!arready_o && arvalid_i) begin
                arready_o <= 1'b1;
            end
        end
    end

endmodule

/* logic/skdecode_top.sv */
// Secret key s1/s2 decode subsystem with an AXI4-Lite slave port.
// irq_o follows the sticky error flag and stays high until a CTRL clear.

`include "skdecode_config.svh"

module skdecode_top (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          awvalid_i,
    output logic                          awready_o,
    input  logic [`SKD_AXI_ADDR_W-1:0]    awaddr_i,
    input  logic                          wvalid_i,
    output logic                          wready_o,
    input  logic [`SKD_AXI_DATA_W-1:0]    wdata_i,
    input  logic [`SKD_AXI_DATA_W/8-1:0]  wstrb_i,
    output logic                          bvalid_o,
    input  logic                          bready_i,
    output logic [1:0]                    bresp_o,
    input  logic                          arvalid_i,
    output logic                          arready_o,
    input  logic [`SKD_AXI_ADDR_W-1:0]    araddr_i,
    output logic                          rvalid_o,
    input  logic                          rready_i,
    output logic [`SKD_AXI_DATA_W-1:0]    rdata_o,
    output logic [1:0]                    rresp_o,
    output logic                          irq_o
);

    skdecode_unpack_if unp ();

    logic                                   wr_en;
    logic [$clog2(`SKD_WORDS)-1:0]          wr_addr;
    skdecode_pkg::coeff_t [`SKD_LANES-1:0]  wr_data;
    logic                                   rd_en;
    logic [`SKD_IDX_W-1:0]                  rd_idx;
    skdecode_pkg::coeff_t                   rd_data;

    skdecode_axil_regs u_regs (
        .clk       (clk),
        .reset_i   (reset_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .awaddr_i  (awaddr_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .bresp_o   (bresp_o),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .araddr_i  (araddr_i),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .unp       (unp.manager),
        .rd_en_o   (rd_en),
        .rd_idx_o  (rd_idx),
        .rd_data_i (rd_data)
    );

    skdecode_unpack_engine u_engine (
        .clk       (clk),
        .reset_i   (reset_i),
        .unp       (unp.worker),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data)
    );

    skdecode_coeff_mem u_mem (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_idx_i  (rd_idx),
        .rd_data_o (rd_data)
    );

    // firmware is interrupted for as long as the engine sits in FAULT
    assign irq_o = unp.error;

endmodule

/* test/skdecode_checker.sv */
// Watches the AXI4-Lite ports of the sk decode DUT and keeps a model of the
// engine, the COEFF_IDX register and the stored coefficients.
// Only one read and one write may be open at a time, as in the DUT.
// A coefficient must be written before it is read back, or its check fails.

`include "skdecode_config.svh"

module skdecode_checker (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          awvalid_i,
    input  logic                          awready_i,
    input  logic [`SKD_AXI_ADDR_W-1:0]    awaddr_i,
    input  logic                          wvalid_i,
    input  logic                          wready_i,
    input  logic [`SKD_AXI_DATA_W-1:0]    wdata_i,
    input  logic                          bvalid_i,
    input  logic                          bready_i,
    input  logic [1:0]                    bresp_i,
    input  logic                          arvalid_i,
    input  logic                          arready_i,
    input  logic [`SKD_AXI_ADDR_W-1:0]    araddr_i,
    input  logic                          rvalid_i,
    input  logic                          rready_i,
    input  logic [`SKD_AXI_DATA_W-1:0]    rdata_i,
    input  logic [1:0]                    rresp_i,
    input  logic                          irq_i,
    input  logic                          test_end_i,
    input  int                            test_id_i,
    output int                            error_count_o,
    output int                            check_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] RespOkay   = 2'b00;
    localparam logic [1:0] RespSlverr = 2'b10;

    logic [`SKD_COEFF_W-1:0]     model_coeff [`SKD_WORDS*`SKD_LANES];
    int                          model_count;
    logic                        model_done;
    logic                        model_error;
    logic [`SKD_IDX_W-1:0]       model_idx;
    logic [1:0]                  exp_bresp;
    logic [1:0]                  exp_rresp;
    logic [`SKD_AXI_DATA_W-1:0]  exp_rdata;
    int                          test_checks;
    int                          test_errors;
    logic                        wr_hs_q;
    int                          rd_delay;

    // eta minus code modulo q, for the legal codes 0 to 4 only
    function automatic logic [`SKD_COEFF_W-1:0] expected_coeff(input logic [2:0] code);
        case (code)
            3'd0:    expected_coeff = 24'd2;
            3'd1:    expected_coeff = 24'd1;
            3'd2:    expected_coeff = 24'd0;
            3'd3:    expected_coeff = `SKD_MLDSA_Q - 1;
            default: expected_coeff = `SKD_MLDSA_Q - 2;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        check_count_o++;
        if ($isunknown(exp) || act !== exp) begin
            test_errors++;
            error_count_o++;
            $display("error: %s expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endtask

    // applies an accepted write to the model and sets the expected response
    task automatic apply_write(input logic [4:0] addr, input logic [31:0] data);
        logic bad;
        bad = 1'b0;
        exp_bresp = RespOkay;
        case (addr)
            skdecode_pkg::CTRL: begin
                if (data[0]) begin
                    model_count = 0;
                    model_done  = 1'b0;
                    model_error = 1'b0;
                end
            end
            skdecode_pkg::SK_DATA: begin
                if (model_done || model_error) begin
                    exp_bresp = RespSlverr;
                end else begin
                    for (int k = 0; k < `SKD_LANES; k++) begin
                        if (data[3*k +: 3] > 3'd4) bad = 1'b1;
                    end
                    // a word with any bad code is dropped and the fault is sticky
                    if (bad) begin
                        model_error = 1'b1;
                    end else begin
                        for (int k = 0; k < `SKD_LANES; k++) begin
                            model_coeff[model_count*`SKD_LANES + k] = expected_coeff(data[3*k +: 3]);
                        end
                        model_count++;
                        if (model_count == `SKD_WORDS) model_done = 1'b1;
                    end
                end
            end
            skdecode_pkg::COEFF_IDX: model_idx = data[`SKD_IDX_W-1:0];
            default: exp_bresp = RespSlverr;
        endcase
    endtask

    // works out the read data and response at the AR handshake
    task automatic predict_read(input logic [4:0] addr);
        exp_rdata = '0;
        exp_rresp = RespOkay;
        case (addr)
            skdecode_pkg::CTRL, skdecode_pkg::SK_DATA: exp_rdata = '0;
            skdecode_pkg::STATUS: begin
                exp_rdata[0]    = model_done;
                exp_rdata[1]    = model_error;
                exp_rdata[13:8] = model_count[5:0];
            end
            skdecode_pkg::COEFF_IDX:  exp_rdata[`SKD_IDX_W-1:0] = model_idx;
            skdecode_pkg::COEFF_DATA: exp_rdata[`SKD_COEFF_W-1:0] = model_coeff[model_idx];
            default: exp_rresp = RespSlverr;
        endcase
    endtask

    initial begin
        error_count_o = 0;
        check_count_o = 0;
        test_checks   = 0;
        test_errors   = 0;
    end

    // sampled at the rising edge, so every value seen is the one before the edge
    always @(posedge clk) begin
        if (reset_i) begin
            model_count = 0;
            model_done  = 1'b0;
            model_error = 1'b0;
            model_idx   = '0;
            wr_hs_q     = 1'b0;
            rd_delay    = 0;
        end else begin
            // awready and wready rise in the same cycle
            if (awready_i || wready_i) check_value("wready", awready_i, wready_i);
            // bvalid follows the write handshake by exactly one cycle
            if (wr_hs_q) check_value("bvalid", 1'b1, bvalid_i);
            wr_hs_q = awvalid_i && awready_i && wvalid_i && wready_i;
            if (wr_hs_q) apply_write(awaddr_i, wdata_i);
            if (bvalid_i && bready_i) begin
                check_value("bresp", exp_bresp, bresp_i);
                check_value("irq_o", model_error, irq_i);
            end
            // rvalid stays low until the read latency has passed, then rises
            if (rd_delay > 0) begin
                rd_delay--;
                check_value("rvalid", rd_delay == 0, rvalid_i);
            end
            if (arvalid_i && arready_i) begin
                predict_read(araddr_i);
                // COEFF_DATA waits one more cycle for the memory
                rd_delay = (araddr_i == skdecode_pkg::COEFF_DATA) ? 2 : 1;
            end
            if (rvalid_i && rready_i) begin
                check_value("rdata", exp_rdata, rdata_i);
                check_value("rresp", exp_rresp, rresp_i);
                check_value("irq_o", model_error, irq_i);
            end
            if (test_end_i) begin
                $display("test %0d: %0d checks, %0d errors", test_id_i, test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

/* test/tb_skdecode.sv */
// Testbench for the sk decode subsystem, driving its AXI4-Lite port.
// Inputs change on the falling clock edge, the checker samples on the rising.
// Random codes come from a 16-bit Galois LFSR and are folded into 0 to 4.

`include "skdecode_config.svh"

module tb_skdecode;

    timeunit 1ns;
    timeprecision 1ps;

    // transactions per test, 1 to 6, an index write and a data read per coefficient
    localparam int Transactions = 1 + 545 + 2 + 90 + 547 + 3;
    localparam int CycleLimit   = 20 * Transactions + 200;

    logic                          clk;
    logic                          reset_i;
    logic                          awvalid;
    logic                          awready;
    logic [`SKD_AXI_ADDR_W-1:0]    awaddr;
    logic                          wvalid;
    logic                          wready;
    logic [`SKD_AXI_DATA_W-1:0]    wdata;
    logic [`SKD_AXI_DATA_W/8-1:0]  wstrb;
    logic                          bvalid;
    logic                          bready;
    logic [1:0]                    bresp;
    logic                          arvalid;
    logic                          arready;
    logic [`SKD_AXI_ADDR_W-1:0]    araddr;
    logic                          rvalid;
    logic                          rready;
    logic [`SKD_AXI_DATA_W-1:0]    rdata;
    logic [1:0]                    rresp;
    logic                          irq;
    logic                          test_end;
    int                            test_id;
    int                            error_count;
    int                            check_count;
    int                            cycles;
    logic [15:0]                   lfsr_q;

    skdecode_top DUT (
        .clk       (clk),
        .reset_i   (reset_i),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .awaddr_i  (awaddr),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .bresp_o   (bresp),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .araddr_i  (araddr),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .irq_o     (irq)
    );

    skdecode_checker u_checker (
        .clk           (clk),
        .reset_i       (reset_i),
        .awvalid_i     (awvalid),
        .awready_i     (awready),
        .awaddr_i      (awaddr),
        .wvalid_i      (wvalid),
        .wready_i      (wready),
        .wdata_i       (wdata),
        .bvalid_i      (bvalid),
        .bready_i      (bready),
        .bresp_i       (bresp),
        .arvalid_i     (arvalid),
        .arready_i     (arready),
        .araddr_i      (araddr),
        .rvalid_i      (rvalid),
        .rready_i      (rready),
        .rdata_i       (rdata),
        .rresp_i       (rresp),
        .irq_i         (irq),
        .test_end_i    (test_end),
        .test_id_i     (test_id),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

    always #4 clk = ~clk;

    // ends a run that stalls on a handshake the DUT never completes
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("timeout: no handshake after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_advance(input logic [15:0] state);
        if (state[0]) begin
            lfsr_advance = (state >> 1) ^ 16'hB400;
        end else begin
            lfsr_advance = state >> 1;
        end
    endfunction

    // three LFSR bits per code, folded into the legal range before packing
    task automatic random_word(output logic [31:0] word);
        logic [2:0] raw;
        word = '0;
        for (int lane = 0; lane < `SKD_LANES; lane++) begin
            for (int b = 0; b < `SKD_ETA_W; b++) begin
                raw[b] = lfsr_q[0];
                lfsr_q = lfsr_advance(lfsr_q);
            end
            word[3*lane +: 3] = (raw > 3'd4) ? raw - 3'd5 : raw;
        end
    endtask

    // AW and W are offered together and dropped after the handshake edge
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] addr);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic read_coeffs(input int count);
        for (int i = 0; i < count; i++) begin
            write_reg(skdecode_pkg::COEFF_IDX, i);
            read_reg(skdecode_pkg::COEFF_DATA);
        end
    endtask

    task automatic write_words(input int count);
        logic [31:0] word;
        for (int i = 0; i < count; i++) begin
            random_word(word);
            write_reg(skdecode_pkg::SK_DATA, word);
        end
    endtask

    // one-cycle marker that makes the checker print the result of a test
    task automatic close_test(input int id);
        test_id  = id;
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        logic [31:0] word;
        clk      = 1'b0;
        reset_i  = 1'b1;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = 4'hF;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        test_end = 1'b0;
        test_id  = 0;
        cycles   = 0;
        lfsr_q   = 16'd53;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // status and interrupt straight after reset
        read_reg(skdecode_pkg::STATUS);
        close_test(1);

        // one full polynomial, then every coefficient read back
        write_words(`SKD_WORDS);
        read_reg(skdecode_pkg::STATUS);
        read_coeffs(`SKD_WORDS * `SKD_LANES);
        close_test(2);

        // a word past the end is refused
        write_words(1);
        read_reg(skdecode_pkg::STATUS);
        close_test(3);

        // five good words, then one with code 6 in lane 3
        write_reg(skdecode_pkg::CTRL, 32'h1);
        write_words(5);
        random_word(word);
        word[11:9] = 3'd6;
        write_reg(skdecode_pkg::SK_DATA, word);
        read_reg(skdecode_pkg::STATUS);
        write_words(2);
        read_coeffs(40);
        close_test(4);

        // recovery from the fault with a fresh polynomial
        write_reg(skdecode_pkg::CTRL, 32'h1);
        read_reg(skdecode_pkg::STATUS);
        write_words(`SKD_WORDS);
        read_reg(skdecode_pkg::STATUS);
        read_coeffs(`SKD_WORDS * `SKD_LANES);
        close_test(5);

        // unmapped address and the read-only STATUS register
        read_reg(5'h14);
        write_reg(5'h14, 32'h0);
        write_reg(skdecode_pkg::STATUS, 32'h0);
        close_test(6);

        $display("tests: 6, checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
logic/skdecode_pkg.sv
logic/skdecode_unpack_if.sv
logic/skdecode_s1s2_unpack.sv
logic/skdecode_unpack_engine.sv
logic/skdecode_coeff_mem.sv
logic/skdecode_axil_regs.sv
logic/skdecode_top.sv
test/skdecode_checker.sv
test/tb_skdecode.sv

/* Bender.yml */
package:
  name: skdecode

export_include_dirs:
  - include

sources:
  - logic/skdecode_pkg.sv
  - logic/skdecode_unpack_if.sv
  - logic/skdecode_s1s2_unpack.sv
  - logic/skdecode_unpack_engine.sv
  - logic/skdecode_coeff_mem.sv
  - logic/skdecode_axil_regs.sv
  - logic/skdecode_top.sv
  - target: test
    files:
      - test/skdecode_checker.sv
      - test/tb_skdecode.sv
